// File: hdl/axi_sys_macros.svh
// AXI to system bus bridge widths and acknowledge timeout

`ifndef AXI_SYS_MACROS_SVH
`define AXI_SYS_MACROS_SVH

// --------------------------------------------------
// AXI slave port

`define AXI_DW 32  // data width
`define AXI_AW 32  // address width
`define AXI_IW 12  // id width, as on the gp0 master port

// --------------------------------------------------
// system bus

// cycles after the enable before an access is given up
// also sets the wait counter width in the access stage
`define SYS_ACK_TIMEOUT 16

`endif

// File: hdl/axi_pkg.sv
// AXI channel payload types and response codes for the single-beat slave port
`default_nettype none

`include "axi_sys_macros.svh"

package axi_pkg;

  // --------------------------------------------------
  // response codes

  typedef enum logic [1:0] {
    AXI_OKAY   = 2'b00,  // normal access done
    AXI_SLVERR = 2'b10   // slave error or timeout
  } axi_resp_e;

  // --------------------------------------------------
  // request channels

  typedef struct packed {
    logic [`AXI_IW-1:0] id;    // write address id
    logic [`AXI_AW-1:0] addr;  // write address
  } axi_aw_t;

  typedef struct packed {
    logic [`AXI_DW-1:0]   data;  // write data
    logic [`AXI_DW/8-1:0] strb;  // byte strobes
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_IW-1:0] id;    // read address id
    logic [`AXI_AW-1:0] addr;  // read address
  } axi_ar_t;

  // response channels
  typedef struct packed {
    logic [`AXI_IW-1:0] id;  // copied from aw
    axi_resp_e          resp;
  } axi_b_t;

  typedef struct packed {
    logic [`AXI_IW-1:0] id;    // copied from ar
    logic [`AXI_DW-1:0] data;  // read data
    axi_resp_e          resp;
  } axi_r_t;

endpackage

`default_nettype wire

// File: hdl/sys_bus_pkg.sv
// System bus request, bridge command and response types with bridge enums
`default_nettype none

`include "axi_sys_macros.svh"

package sys_bus_pkg;

  import axi_pkg::*;

  typedef enum logic {
    SYS_WRITE = 1'b0,  // pulses sys_wen
    SYS_READ  = 1'b1   // pulses sys_ren
  } sys_op_e;

  typedef enum logic [1:0] {
    ACC_IDLE   = 2'd0,  // no access running
    ACC_STROBE = 2'd1,  // enable cycle
    ACC_WAIT   = 2'd2   // waiting for ack or err
  } access_state_e;

  // --------------------------------------------------
  // what the bridge puts on the system bus
  typedef struct packed {
    logic [`AXI_AW-1:0]   addr;   // read/write address
    logic [`AXI_DW-1:0]   wdata;  // write data
    logic [`AXI_DW/8-1:0] sel;    // write byte select
  } sys_req_t;

  // capture -> access
  typedef struct packed {
    logic [`AXI_IW-1:0] id;
    sys_op_e            op;
    sys_req_t           req;
  } bus_cmd_t;

  // access -> return
  typedef struct packed {
    logic [`AXI_IW-1:0] id;
    sys_op_e            op;     // picks b or r channel
    logic [`AXI_DW-1:0] rdata;  // zero on error
    axi_resp_e          resp;
  } bus_rsp_t;

endpackage

`default_nettype wire

// File: hdl/axi_req_capture.sv
// Request capture stage, pairs AXI write address and data, arbitrates reads, holds one command
`timescale 1ns/10ps
`default_nettype none

module axi_req_capture import axi_pkg::*, sys_bus_pkg::*; (
  input  wire logic     axi_clk_i,   // global clock
  input  wire logic     rst_i,       // sync reset, active high
  // write address channel
  input  wire axi_aw_t  aw_i,
  input  wire logic     aw_valid_i,
  output logic          aw_ready_o,
  // write data channel
  input  wire axi_w_t   w_i,
  input  wire logic     w_valid_i,
  output logic          w_ready_o,
  // read address channel
  input  wire axi_ar_t  ar_i,
  input  wire logic     ar_valid_i,
  output logic          ar_ready_o,
  // command to access stage
  output bus_cmd_t      cmd_o,
  output logic          cmd_valid_o,
  input  wire logic     cmd_ready_i
);

  bus_cmd_t cmd_q;          // held command
  logic     cmd_valid_q;
  logic     last_wr_q;      // last grant went to a write
  logic     can_load;       // register free this cycle
  logic     wr_pend;        // full write pair present
  logic     rd_pend;
  logic     wr_wins;
  logic     rd_wins;
  logic     wr_go;          // aw and w taken
  logic     rd_go;          // ar taken

  // --------------------------------------------------
  // arbitration

  assign can_load = !cmd_valid_q || cmd_ready_i;  // empty or draining now
  assign wr_pend  = aw_valid_i && w_valid_i;
  assign rd_pend  = ar_valid_i;

  // write first after reset, then alternate on contention
  assign wr_wins = wr_pend && (!rd_pend || !last_wr_q);
  assign rd_wins = rd_pend && !wr_wins;

  // ready high when idle, low while only half of a write pair is there
  assign aw_ready_o = can_load && !rd_wins && !(aw_valid_i ^ w_valid_i);
  assign w_ready_o  = aw_ready_o;                 // both beats move together
  assign ar_ready_o = can_load && !wr_wins;

  assign wr_go = wr_pend && aw_ready_o;
  assign rd_go = ar_valid_i && ar_ready_o;

  // --------------------------------------------------
  // control state

  always_ff @(posedge axi_clk_i) begin
    if (rst_i) begin
      cmd_valid_q <= 1'b0;
      last_wr_q   <= 1'b0;                        // write has first go
    end else begin
      if (wr_go || rd_go)
        cmd_valid_q <= 1'b1;
      else if (cmd_ready_i)
        cmd_valid_q <= 1'b0;                      // taken, nothing new
      if (wr_go)
        last_wr_q <= 1'b1;
      else if (rd_go)
        last_wr_q <= 1'b0;
    end
  end

  // command payload
  always_ff @(posedge axi_clk_i) begin
    if (wr_go) begin
      cmd_q.id        <= aw_i.id;
      cmd_q.op        <= SYS_WRITE;
      cmd_q.req.addr  <= aw_i.addr;
      cmd_q.req.wdata <= w_i.data;
      cmd_q.req.sel   <= w_i.strb;
    end else if (rd_go) begin
      cmd_q.id        <= ar_i.id;
      cmd_q.op        <= SYS_READ;
      cmd_q.req.addr  <= ar_i.addr;
      cmd_q.req.wdata <= '0;                      // unused on reads
      cmd_q.req.sel   <= '0;
    end
  end

  assign cmd_o       = cmd_q;
  assign cmd_valid_o = cmd_valid_q;

endmodule

`default_nettype wire

// File: hdl/sys_bus_access.sv
// System bus access stage, one enable strobe per command, waits for ack or err with a timeout
`timescale 1ns/10ps
`default_nettype none

`include "axi_sys_macros.svh"

module sys_bus_access import axi_pkg::*, sys_bus_pkg::*; (
  input  wire logic               axi_clk_i,    // global clock
  input  wire logic               rst_i,        // sync reset, active high
  // command from capture stage
  input  wire bus_cmd_t           cmd_i,
  input  wire logic               cmd_valid_i,
  output logic                    cmd_ready_o,
  // result to return stage
  output bus_rsp_t                rsp_o,
  output logic                    rsp_valid_o,
  input  wire logic               rsp_ready_i,
  // system bus
  output sys_req_t                sys_req_o,    // addr, wdata, sel
  output logic                    sys_wen_o,    // write enable
  output logic                    sys_ren_o,    // read enable
  input  wire logic [`AXI_DW-1:0] sys_rdata_i,  // read data
  input  wire logic               sys_ack_i,    // acknowledge
  input  wire logic               sys_err_i     // error indicator
);

  localparam int CNT_W = $clog2(`SYS_ACK_TIMEOUT);

  access_state_e      state_q;
  logic [CNT_W-1:0]   cnt_q;       // wait cycles so far
  bus_cmd_t           cmd_q;       // command in service
  logic [`AXI_DW-1:0] rdata_q;
  axi_resp_e          resp_q;
  logic               rsp_valid_q; // unread result
  logic               take;
  logic               timeout;
  logic               done;        // access ends this cycle
  logic               ok;

  // --------------------------------------------------
  // handshake and end of access

  assign cmd_ready_o = (state_q == ACC_IDLE) && !rsp_valid_q;
  assign take        = cmd_valid_i && cmd_ready_o;
  assign timeout     = (cnt_q == CNT_W'(`SYS_ACK_TIMEOUT - 1));  // last wait cycle
  assign done        = (state_q == ACC_WAIT) && (sys_ack_i || sys_err_i || timeout);
  assign ok          = sys_ack_i && !sys_err_i;                  // err wins over ack

  always_ff @(posedge axi_clk_i) begin
    if (rst_i) begin
      state_q     <= ACC_IDLE;
      cnt_q       <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      case (state_q)
        ACC_IDLE:   if (take) state_q <= ACC_STROBE;
        ACC_STROBE: begin
          state_q <= ACC_WAIT;
          cnt_q   <= '0;
        end
        ACC_WAIT: begin
          if (done)
            state_q <= ACC_IDLE;
          else
            cnt_q <= cnt_q + 1'b1;
        end
        default:    state_q <= ACC_IDLE;
      endcase
      if (done)
        rsp_valid_q <= 1'b1;                   // offered next cycle
      else if (rsp_ready_i)
        rsp_valid_q <= 1'b0;
    end
  end

  // payload registers
  always_ff @(posedge axi_clk_i) begin
    if (take)
      cmd_q <= cmd_i;
    if (done) begin
      resp_q  <= ok ? AXI_OKAY : AXI_SLVERR;
      rdata_q <= (ok && cmd_q.op == SYS_READ) ? sys_rdata_i : '0;
    end
  end

  // --------------------------------------------------
  // outputs

  assign sys_req_o = cmd_q.req;                  // stable until done
  assign sys_wen_o = (state_q == ACC_STROBE) && (cmd_q.op == SYS_WRITE);
  assign sys_ren_o = (state_q == ACC_STROBE) && (cmd_q.op == SYS_READ);

  assign rsp_o.id    = cmd_q.id;
  assign rsp_o.op    = cmd_q.op;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.resp  = resp_q;
  assign rsp_valid_o = rsp_valid_q;

endmodule

`default_nettype wire

// File: hdl/axi_rsp_return.sv
// Response return stage, holds one result and steers it to the AXI write response or read data channel
`timescale 1ns/10ps
`default_nettype none

module axi_rsp_return import axi_pkg::*, sys_bus_pkg::*; (
  input  wire logic     axi_clk_i,  // global clock
  input  wire logic     rst_i,      // sync reset, active high
  // result from access stage
  input  wire bus_rsp_t rsp_i,
  input  wire logic     rsp_valid_i,
  output logic          rsp_ready_o,
  // write response channel
  output axi_b_t        b_o,
  output logic          b_valid_o,
  input  wire logic     b_ready_i,
  // read data channel
  output axi_r_t        r_o,
  output logic          r_valid_o,
  input  wire logic     r_ready_i
);

  bus_rsp_t rsp_q;
  logic     full_q;
  logic     fire;  // held response leaves this cycle

  assign b_valid_o   = full_q && (rsp_q.op == SYS_WRITE);
  assign r_valid_o   = full_q && (rsp_q.op == SYS_READ);
  assign fire        = (b_valid_o && b_ready_i) || (r_valid_o && r_ready_i);
  assign rsp_ready_o = !full_q || fire;          // refill in the same cycle

  always_ff @(posedge axi_clk_i) begin
    if (rst_i)
      full_q <= 1'b0;
    else if (rsp_valid_i && rsp_ready_o)
      full_q <= 1'b1;
    else if (fire)
      full_q <= 1'b0;
  end

  always_ff @(posedge axi_clk_i) begin
    if (rsp_valid_i && rsp_ready_o)
      rsp_q <= rsp_i;
  end

  // payloads follow the held response
  assign b_o.id   = rsp_q.id;
  assign b_o.resp = rsp_q.resp;
  assign r_o.id   = rsp_q.id;
  assign r_o.data = rsp_q.rdata;
  assign r_o.resp = rsp_q.resp;

endmodule

`default_nettype wire

// File: hdl/axi_sys_bridge.sv
// AXI slave to system bus bridge top, capture, access and return stages in a chain
`timescale 1ns/10ps
`default_nettype none

`include "axi_sys_macros.svh"

module axi_sys_bridge import axi_pkg::*, sys_bus_pkg::*; (
  input  wire logic               axi_clk_i,    // global clock
  input  wire logic               rst_i,        // sync reset, active high
  // AXI slave port
  input  wire axi_aw_t            aw_i,
  input  wire logic               aw_valid_i,
  output logic                    aw_ready_o,
  input  wire axi_w_t             w_i,
  input  wire logic               w_valid_i,
  output logic                    w_ready_o,
  input  wire axi_ar_t            ar_i,
  input  wire logic               ar_valid_i,
  output logic                    ar_ready_o,
  output axi_b_t                  b_o,
  output logic                    b_valid_o,
  input  wire logic               b_ready_i,
  output axi_r_t                  r_o,
  output logic                    r_valid_o,
  input  wire logic               r_ready_i,
  // system bus
  output sys_req_t                sys_req_o,
  output logic                    sys_wen_o,
  output logic                    sys_ren_o,
  input  wire logic [`AXI_DW-1:0] sys_rdata_i,
  input  wire logic               sys_ack_i,
  input  wire logic               sys_err_i
);

  bus_cmd_t cmd;        // capture -> access
  logic     cmd_valid;
  logic     cmd_ready;
  bus_rsp_t rsp;        // access -> return
  logic     rsp_valid;
  logic     rsp_ready;

  // --------------------------------------------------
  // stages

  axi_req_capture u_capture (
    .axi_clk_i   (axi_clk_i),
    .rst_i       (rst_i),
    .aw_i        (aw_i),
    .aw_valid_i  (aw_valid_i),
    .aw_ready_o  (aw_ready_o),
    .w_i         (w_i),
    .w_valid_i   (w_valid_i),
    .w_ready_o   (w_ready_o),
    .ar_i        (ar_i),
    .ar_valid_i  (ar_valid_i),
    .ar_ready_o  (ar_ready_o),
    .cmd_o       (cmd),
    .cmd_valid_o (cmd_valid),
    .cmd_ready_i (cmd_ready)
  );

  sys_bus_access u_access (
    .axi_clk_i   (axi_clk_i),
    .rst_i       (rst_i),
    .cmd_i       (cmd),
    .cmd_valid_i (cmd_valid),
    .cmd_ready_o (cmd_ready),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .sys_req_o   (sys_req_o),
    .sys_wen_o   (sys_wen_o),
    .sys_ren_o   (sys_ren_o),
    .sys_rdata_i (sys_rdata_i),
    .sys_ack_i   (sys_ack_i),
    .sys_err_i   (sys_err_i)
  );

  axi_rsp_return u_return (
    .axi_clk_i   (axi_clk_i),
    .rst_i       (rst_i),
    .rsp_i       (rsp),
    .rsp_valid_i (rsp_valid),
    .rsp_ready_o (rsp_ready),
    .b_o         (b_o),
    .b_valid_o   (b_valid_o),
    .b_ready_i   (b_ready_i),
    .r_o         (r_o),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i)
  );

endmodule

`default_nettype wire

// File: verification/axi_sys_bridge_chk.sv
// Protocol checker for the AXI to system bus bridge, bound into the bridge top
`timescale 1ns/10ps
`default_nettype none

module axi_sys_bridge_chk import axi_pkg::*; (
  input wire logic   clk_i,
  input wire logic   rst_i,
  input wire logic   wen_i,       // system bus enables
  input wire logic   ren_i,
  input wire axi_b_t b_i,
  input wire logic   b_valid_i,
  input wire logic   b_ready_i,
  input wire axi_r_t r_i,
  input wire logic   r_valid_i,
  input wire logic   r_ready_i,
  input wire logic   aw_valid_i,
  input wire logic   aw_ready_i,
  input wire logic   w_valid_i,
  input wire logic   w_ready_i
);

  int fail_cnt = 0;  // read by the testbench at the end

  // --------------------------------------------------
  // system bus strobes

  a_no_overlap: assert property (@(posedge clk_i) disable iff (rst_i)
    !(wen_i && ren_i)) else begin $error("wen and ren high together"); fail_cnt++; end

  a_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    (wen_i || ren_i) |=> !(wen_i || ren_i))
    else begin $error("enable longer than one cycle"); fail_cnt++; end

  // --------------------------------------------------
  // AXI side

  a_b_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (b_valid_i && !b_ready_i) |=> (b_valid_i && $stable(b_i)))
    else begin $error("b payload changed under back-pressure"); fail_cnt++; end

  a_r_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (r_valid_i && !r_ready_i) |=> (r_valid_i && $stable(r_i)))
    else begin $error("r payload changed under back-pressure"); fail_cnt++; end

  // address and data beats of a write move in the same cycle
  a_aw_w_pair: assert property (@(posedge clk_i) disable iff (rst_i)
    (aw_valid_i && aw_ready_i) == (w_valid_i && w_ready_i))
    else begin $error("aw and w beats taken in different cycles"); fail_cnt++; end

endmodule

bind axi_sys_bridge axi_sys_bridge_chk i_chk (
  .clk_i      (axi_clk_i),
  .rst_i      (rst_i),
  .wen_i      (sys_wen_o),
  .ren_i      (sys_ren_o),
  .b_i        (b_o),
  .b_valid_i  (b_valid_o),
  .b_ready_i  (b_ready_i),
  .r_i        (r_o),
  .r_valid_i  (r_valid_o),
  .r_ready_i  (r_ready_i),
  .aw_valid_i (aw_valid_i),
  .aw_ready_i (aw_ready_o),
  .w_valid_i  (w_valid_i),
  .w_ready_i  (w_ready_o)
);

`default_nettype wire

// File: verification/tb_axi_sys_bridge.sv
// Testbench for the AXI to system bus bridge, random AXI traffic against a system bus model
`timescale 1ns/10ps
`default_nettype none

`include "axi_sys_macros.svh"

module tb_axi_sys_bridge import axi_pkg::*, sys_bus_pkg::*; ();

  localparam int REQ_LIMIT = 200;  // cycles to wait for aw/ar ready

  logic axi_clk_i, rst_i;
  axi_aw_t aw_i;
  axi_w_t w_i;
  axi_ar_t ar_i;
  axi_b_t b_o;
  axi_r_t r_o;
  logic aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, ar_valid_i, ar_ready_o;
  logic b_valid_o, b_ready_i, r_valid_o, r_ready_i;
  sys_req_t sys_req_o;
  logic sys_wen_o, sys_ren_o, sys_ack_i, sys_err_i;
  logic [`AXI_DW-1:0] sys_rdata_i;

  logic [31:0] mem [256];     // system bus memory
  logic [31:0] shadow [256];  // what the memory should hold
  axi_b_t exp_b [$];          // expected write responses, in order
  axi_r_t exp_r [$];
  logic [31:0] seed_req, seed_bus, seed_rdy;
  logic rdy_all;              // hold b/r ready high
  int errors, total;
  logic [3:0] bus_region;
  logic [7:0] bus_idx;
  logic bus_wr;
  int bus_delay, bk;

  axi_sys_bridge i_dut (.*);

  always #20 axi_clk_i = ~axi_clk_i;  // 40 ns period

  function automatic logic [31:0] xorshift(inout logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // --------------------------------------------------
  // request side, one request at a time so acceptance order is issue order

  task automatic issue(input logic is_wr, input logic [11:0] tid, input logic [31:0] addr,
                       input logic [31:0] data, input logic [3:0] strb);
    axi_resp_e code;
    logic [7:0] idx;
    logic ok;
    int n;
    int k;
    idx  = addr[9:2];
    code = (addr[15:12] == 4'hE || addr[15:12] == 4'hF) ? AXI_SLVERR : AXI_OKAY;
    if (is_wr) begin
      exp_b.push_back('{id: tid, resp: code});
      if (code == AXI_OKAY)
        for (k = 0; k < 4; k++)
          if (strb[k]) shadow[idx][8*k +: 8] = data[8*k +: 8];  // byte merge
    end else begin
      exp_r.push_back('{id: tid, data: (code == AXI_OKAY) ? shadow[idx] : 32'h0, resp: code});
    end
    aw_i = '{id: tid, addr: addr};
    ar_i = '{id: tid, addr: addr};
    w_i  = '{data: data, strb: strb};
    aw_valid_i = is_wr;
    w_valid_i  = is_wr;
    ar_valid_i = !is_wr;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < REQ_LIMIT) begin
      #4;                                       // ready settled mid cycle
      ok = is_wr ? (aw_ready_o && w_ready_o) : ar_ready_o;
      @(posedge axi_clk_i);
      #1;
      n++;
    end
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    ar_valid_i = 1'b0;
    if (!ok) begin
      $display("ERROR: request to address %h was never accepted", addr);
      errors++;
    end
  endtask

  task automatic wait_drain(input int limit, input string what);
    int n;
    n = 0;
    while ((exp_b.size() != 0 || exp_r.size() != 0) && n < limit) begin
      @(posedge axi_clk_i);
      #1;
      n++;
    end
    if (exp_b.size() != 0 || exp_r.size() != 0) begin
      $display("ERROR: %s, responses still missing after %0d cycles", what, limit);
      errors++;
    end
  endtask

  // --------------------------------------------------
  // response side, random ready and in-order compare

  always begin
    @(posedge axi_clk_i);
    #1;
    b_ready_i = rdy_all || (xorshift(seed_rdy) % 4 != 0);
    r_ready_i = rdy_all || (xorshift(seed_rdy) % 4 != 0);
    if (b_valid_o && b_ready_i) begin                 // transfer at next edge
      if (exp_b.size() == 0) begin
        $display("ERROR: write response arrived with none expected");
        errors++;
      end else
        check("write response", exp_b.pop_front(), b_o);
    end
    if (r_valid_o && r_ready_i) begin
      if (exp_r.size() == 0) begin
        $display("ERROR: read response arrived with none expected");
        errors++;
      end else
        check("read response", exp_r.pop_front(), r_o);
    end
  end

  // system bus model, E region errors, F region stays silent
  always begin
    @(posedge axi_clk_i);
    #1;
    if (sys_wen_o || sys_ren_o) begin
      bus_wr     = sys_wen_o;
      bus_region = sys_req_o.addr[15:12];
      bus_idx    = sys_req_o.addr[9:2];
      if (bus_region != 4'hF) begin
        bus_delay = xorshift(seed_bus) % 6;           // 0 to 5 extra cycles
        repeat (bus_delay + 1) @(posedge axi_clk_i);
        #1;
        if (bus_region == 4'hE) begin
          sys_err_i   = 1'b1;
          sys_rdata_i = 32'hBAD0_0BAD;                // must not reach r
        end else begin
          sys_ack_i   = 1'b1;
          sys_rdata_i = bus_wr ? 32'h0 : mem[bus_idx];
          if (bus_wr)
            for (bk = 0; bk < 4; bk++)
              if (sys_req_o.sel[bk]) mem[bus_idx][8*bk +: 8] = sys_req_o.wdata[8*bk +: 8];
        end
        @(posedge axi_clk_i);
        #1;
        sys_ack_i   = 1'b0;
        sys_err_i   = 1'b0;
        sys_rdata_i = '0;
      end
    end
  end

  // --------------------------------------------------
  // main sequence

  initial begin
    logic [31:0] v, d, s;
    logic [3:0] region;
    logic [7:0] fi;
    int i;
    axi_clk_i = 1'b0;
    rst_i = 1'b1;
    aw_i = '0;
    w_i = '0;
    ar_i = '0;
    aw_valid_i = 1'b0;
    w_valid_i = 1'b0;
    ar_valid_i = 1'b0;
    b_ready_i = 1'b0;
    r_ready_i = 1'b0;
    sys_rdata_i = '0;
    sys_ack_i = 1'b0;
    sys_err_i = 1'b0;
    rdy_all = 1'b0;
    errors = 0;
    seed_req = 32'd23;
    seed_bus = 32'd23;
    seed_rdy = 32'd23;
    for (i = 0; i < 256; i++) begin
      fi = 8'(i);
      mem[i]    = {8'hA5, fi, ~fi, fi ^ 8'h3C};      // every word distinct
      shadow[i] = mem[i];
    end
    repeat (8) @(posedge axi_clk_i);
    #1;
    rst_i = 1'b0;
    repeat (4) begin                                  // quiet before any request
      @(posedge axi_clk_i);
      #1;
      check("idle after reset", 64'h0, {b_valid_o, r_valid_o, sys_wen_o, sys_ren_o});
      check("ready after reset", 64'h7, {aw_ready_o, w_ready_o, ar_ready_o});
    end
    for (i = 0; i < 150; i++) begin
      v = xorshift(seed_req);
      d = xorshift(seed_req);
      s = xorshift(seed_req);
      region = (v[3:0] == 4'h0) ? 4'hF : (v[3:0] == 4'h1) ? 4'hE : 4'h0;
      issue(v[8], s[11:0], {16'h0, region, 6'h0, v[7:4], 2'b00}, d, s[15:12]);
    end
    wait_drain(1000, "random traffic");
    rdy_all = 1'b1;
    issue(1'b1, 12'hF0F, 32'h0000_F010, 32'hDEAD_BEEF, 4'hF);
    wait_drain(`SYS_ACK_TIMEOUT + 10, "silent region write");
    issue(1'b0, 12'h0F0, 32'h0000_F014, 32'h0, 4'h0);
    wait_drain(`SYS_ACK_TIMEOUT + 10, "silent region read");
    total = errors + i_dut.i_chk.fail_cnt;
    $display("test done, %0d check errors, %0d assertion failures",
             errors, i_dut.i_chk.fail_cnt);
    if (total == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+hdl
hdl/axi_pkg.sv
hdl/sys_bus_pkg.sv
hdl/axi_req_capture.sv
hdl/sys_bus_access.sv
hdl/axi_rsp_return.sv
hdl/axi_sys_bridge.sv
verification/axi_sys_bridge_chk.sv
verification/tb_axi_sys_bridge.sv

// File: Makefile
SIM   = verilator
FLAGS = --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
TOP   = tb_axi_sys_bridge
FLIST = files.f

SRCS  = $(filter-out +incdir+%,$(shell cat $(FLIST))) $(wildcard hdl/*.svh)
BIN   = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
